// File: logic/alu_pkg.sv
package alu_pkg;

   typedef logic [31:0] word_t;        // scalar operand or result
   typedef logic [63:0] mmx_t;         // MMX operand, also the ALU output width
   typedef logic [5:0]  flags_t;       // OF SF ZF AF CF PF, bit 5 down to 0
   typedef logic [4:0]  shift_count_t;

   // codes keep the numbering of the full datapath, gaps are unused ops
   typedef enum logic [3:0] {
      ALU_PASS   = 4'd0,
      ALU_ADD    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_PMINSW = 4'd4,
      ALU_NOT    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_PADDW  = 4'd9,
      ALU_PADDD  = 4'd10,
      ALU_PMAXSW = 4'd11,
      ALU_SAL    = 4'd12,
      ALU_SAR    = 4'd13
   } alu_op_t;

   typedef enum logic [2:0] {
      SIZE_8  = 3'd1,
      SIZE_16 = 3'd2,
      SIZE_32 = 3'd3     // other encodings behave as 32 bits
   } opsize_t;

   typedef enum logic [1:0] {LOGIC_AND, LOGIC_OR, LOGIC_NOT} logic_fn_t;

   typedef enum logic [1:0] {PK_ADDW, PK_ADDD, PK_MAXW, PK_MINW} packed_fn_t;

   // flag positions
   localparam int FLAG_OF = 5;
   localparam int FLAG_SF = 4;
   localparam int FLAG_ZF = 3;
   localparam int FLAG_AF = 2;
   localparam int FLAG_CF = 1;
   localparam int FLAG_PF = 0;

   localparam flags_t MASK_ARITH      = 6'b111111;
   localparam flags_t MASK_LOGIC      = 6'b111011;   // AF left untouched
   localparam flags_t MASK_NONE       = 6'b000000;
   localparam flags_t MASK_SHIFT_BASE = 6'b011011;   // SF ZF CF PF

   localparam int LANE_W = 16;   // MMX word lane

endpackage

// File: logic/alu_adder.sv
module alu_adder (
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  alu_pkg::opsize_t opsize,
   output alu_pkg::word_t   sum,
   output alu_pkg::flags_t  flags
);
   import alu_pkg::*;

   logic [8:0]  sum8;
   logic [16:0] sum16;
   logic [32:0] sum32;
   logic [4:0]  low_nibble;    // carry out of bit 3 gives AF
   logic        top;           // sign bit of the sized sum
   logic        carry;
   logic        ovf;

   assign sum8       = {1'b0, a[7:0]} + {1'b0, b[7:0]};
   assign sum16      = {1'b0, a[15:0]} + {1'b0, b[15:0]};
   assign sum32      = {1'b0, a} + {1'b0, b};
   assign low_nibble = {1'b0, a[3:0]} + {1'b0, b[3:0]};

   always_comb begin
      case (opsize)
         SIZE_8: begin
            sum   = {24'h0, sum8[7:0]};
            carry = sum8[8];
            top   = sum8[7];
            ovf   = (a[7] == b[7]) && (top != a[7]);   // same signs in, other sign out
         end
         SIZE_16: begin
            sum   = {16'h0, sum16[15:0]};
            carry = sum16[16];
            top   = sum16[15];
            ovf   = (a[15] == b[15]) && (top != a[15]);
         end
         default: begin
            sum   = sum32[31:0];
            carry = sum32[32];
            top   = sum32[31];
            ovf   = (a[31] == b[31]) && (top != a[31]);
         end
      endcase

      flags          = '0;   // PF is added by the core from the final result
      flags[FLAG_OF] = ovf;
      flags[FLAG_SF] = top;
      flags[FLAG_ZF] = (sum == '0);   // upper bits are already zero
      flags[FLAG_AF] = low_nibble[4];
      flags[FLAG_CF] = carry;
   end

endmodule

// File: logic/alu_logic_unit.sv
module alu_logic_unit (
   input  alu_pkg::word_t    a,
   input  alu_pkg::word_t    b,
   input  alu_pkg::opsize_t  opsize,
   input  alu_pkg::logic_fn_t fn,
   output alu_pkg::word_t    result,
   output alu_pkg::flags_t   flags
);
   import alu_pkg::*;

   word_t raw;   // full-width bitwise result before sizing

   always_comb begin
      case (fn)
         LOGIC_AND: raw = a & b;
         LOGIC_OR:  raw = a | b;
         LOGIC_NOT: raw = ~a;     // b is ignored
         default:   raw = '0;
      endcase
   end

   // OF, CF and AF stay zero for the logic ops
   always_comb begin
      flags = '0;
      case (opsize)
         SIZE_8: begin
            result         = {24'h0, raw[7:0]};
            flags[FLAG_SF] = raw[7];
         end
         SIZE_16: begin
            result         = {16'h0, raw[15:0]};
            flags[FLAG_SF] = raw[15];
         end
         default: begin
            result         = raw;
            flags[FLAG_SF] = raw[31];
         end
      endcase
      flags[FLAG_ZF] = (result == '0);
   end

endmodule

// File: logic/alu_shifter.sv
module alu_shifter (
   input  alu_pkg::word_t        a,
   input  alu_pkg::shift_count_t count,
   input  alu_pkg::opsize_t      opsize,
   input  logic                  arith_right,
   output alu_pkg::word_t        result,
   output alu_pkg::flags_t       flags,
   output alu_pkg::flags_t       set_mask
);
   import alu_pkg::*;

   word_t       sized;       // operand zero-extended from its size
   word_t       sign_ext;    // operand sign-extended from its size
   logic [32:0] sal_wide;    // one spare bit on top for the carry out
   logic [32:0] sar_wide;    // bit 0 catches the last bit shifted out
   word_t       shifted;
   logic        top;
   logic        carry;

   always_comb begin
      case (opsize)
         SIZE_8: begin
            sized    = {24'h0, a[7:0]};
            sign_ext = {{24{a[7]}}, a[7:0]};
         end
         SIZE_16: begin
            sized    = {16'h0, a[15:0]};
            sign_ext = {{16{a[15]}}, a[15:0]};
         end
         default: begin
            sized    = a;
            sign_ext = a;
         end
      endcase
   end

   assign sal_wide = {1'b0, sized} << count;
   assign sar_wide = $signed({sign_ext, 1'b0}) >>> count;
   assign shifted  = arith_right ? sar_wide[32:1] : sal_wide[31:0];

   always_comb begin
      case (opsize)
         SIZE_8: begin
            result = {24'h0, shifted[7:0]};
            top    = shifted[7];
            carry  = arith_right ? sar_wide[0] : sal_wide[8];
         end
         SIZE_16: begin
            result = {16'h0, shifted[15:0]};
            top    = shifted[15];
            carry  = arith_right ? sar_wide[0] : sal_wide[16];
         end
         default: begin
            result = shifted;
            top    = shifted[31];
            carry  = arith_right ? sar_wide[0] : sal_wide[32];
         end
      endcase

      flags          = '0;
      flags[FLAG_OF] = !arith_right && (top ^ carry);   // SAR clears OF
      flags[FLAG_SF] = top;
      flags[FLAG_ZF] = (result == '0);
      flags[FLAG_CF] = carry;
   end

   // zero count leaves every flag alone, OF only defined for a single-bit shift
   always_comb begin
      set_mask = MASK_NONE;
      if (count != '0) begin
         set_mask          = MASK_SHIFT_BASE;
         set_mask[FLAG_OF] = (count == 5'd1);
      end
   end

endmodule

// File: logic/alu_packed_unit.sv
module alu_packed_unit (
   input  alu_pkg::mmx_t       a,
   input  alu_pkg::mmx_t       b,
   input  alu_pkg::packed_fn_t fn,
   output alu_pkg::mmx_t       result
);
   import alu_pkg::*;

   mmx_t add_w;
   mmx_t add_d;
   mmx_t max_w;
   mmx_t min_w;

   // one slice per 16-bit lane
   for (genvar i = 0; i < $bits(mmx_t) / LANE_W; i++) begin : g_lane
      logic signed [LANE_W-1:0] lane_a;
      logic signed [LANE_W-1:0] lane_b;
      logic                     a_greater;

      assign lane_a    = a[i*LANE_W +: LANE_W];
      assign lane_b    = b[i*LANE_W +: LANE_W];
      assign a_greater = (lane_a > lane_b);   // signed compare

      assign add_w[i*LANE_W +: LANE_W] = lane_a + lane_b;   // wraps, no carry across lanes
      assign max_w[i*LANE_W +: LANE_W] = a_greater ? lane_a : lane_b;
      assign min_w[i*LANE_W +: LANE_W] = a_greater ? lane_b : lane_a;
   end

   // doubleword lanes
   assign add_d[63:32] = a[63:32] + b[63:32];
   assign add_d[31:0]  = a[31:0] + b[31:0];

   always_comb begin
      case (fn)
         PK_ADDW: result = add_w;
         PK_ADDD: result = add_d;
         PK_MAXW: result = max_w;
         PK_MINW: result = min_w;
         default: result = '0;
      endcase
   end

endmodule

// File: logic/alu_core.sv
module alu_core (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              op_valid,
   input  alu_pkg::alu_op_t  alu_op,
   input  alu_pkg::opsize_t  opsize,
   input  alu_pkg::mmx_t     a,
   input  alu_pkg::mmx_t     b,
   output logic              result_valid,
   output alu_pkg::mmx_t     alu_out,
   output alu_pkg::flags_t   set_eflags,
   output alu_pkg::flags_t   eflags_out
);
   import alu_pkg::*;

   typedef enum logic [2:0] {
      SEL_NONE, SEL_PASS, SEL_ADD, SEL_LOGIC, SEL_SHIFT, SEL_PACKED
   } unit_sel_t;

   unit_sel_t  sel;
   logic_fn_t  lfn;
   packed_fn_t pfn;
   logic       arith_right;
   word_t      add_sum, log_result, sh_result;
   flags_t     add_flags, log_flags, sh_flags, sh_mask;
   mmx_t       pk_result;
   mmx_t       res;
   flags_t     flg;
   flags_t     mask;

   alu_adder u_adder (.a(a[31:0]), .b(b[31:0]), .opsize(opsize), .sum(add_sum), .flags(add_flags));

   alu_logic_unit u_logic (.a(a[31:0]), .b(b[31:0]), .opsize(opsize), .fn(lfn),
                           .result(log_result), .flags(log_flags));

   alu_shifter u_shifter (.a(a[31:0]), .count(b[4:0]), .opsize(opsize), .arith_right(arith_right),
                          .result(sh_result), .flags(sh_flags), .set_mask(sh_mask));

   alu_packed_unit u_packed (.a(a), .b(b), .fn(pfn), .result(pk_result));

   // op decode
   always_comb begin
      sel         = SEL_NONE;
      lfn         = LOGIC_AND;
      pfn         = PK_ADDW;
      arith_right = 1'b0;
      case (alu_op)
         ALU_PASS:   sel = SEL_PASS;
         ALU_ADD:    sel = SEL_ADD;
         ALU_AND:    sel = SEL_LOGIC;
         ALU_OR:     begin sel = SEL_LOGIC; lfn = LOGIC_OR; end
         ALU_NOT:    begin sel = SEL_LOGIC; lfn = LOGIC_NOT; end
         ALU_SAL:    sel = SEL_SHIFT;
         ALU_SAR:    begin sel = SEL_SHIFT; arith_right = 1'b1; end
         ALU_PADDW:  sel = SEL_PACKED;
         ALU_PADDD:  begin sel = SEL_PACKED; pfn = PK_ADDD; end
         ALU_PMAXSW: begin sel = SEL_PACKED; pfn = PK_MAXW; end
         ALU_PMINSW: begin sel = SEL_PACKED; pfn = PK_MINW; end
         default:    sel = SEL_NONE;   // unused codes give zero
      endcase
   end

   // result, flag and mask select
   always_comb begin
      res  = '0;
      flg  = '0;
      mask = MASK_NONE;
      case (sel)
         SEL_PASS:   res = a;
         SEL_ADD:    begin res = {32'h0, add_sum}; flg = add_flags; mask = MASK_ARITH; end
         SEL_LOGIC: begin
            res  = {32'h0, log_result};
            flg  = log_flags;
            mask = (lfn == LOGIC_NOT) ? MASK_NONE : MASK_LOGIC;   // NOT writes no flags
         end
         SEL_SHIFT:  begin res = {32'h0, sh_result}; flg = sh_flags; mask = sh_mask; end
         SEL_PACKED: res = pk_result;
         default:    res = '0;
      endcase
      flg[FLAG_PF] = ~^res[7:0];   // even parity of the low result byte
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_valid <= 1'b0;
         alu_out      <= '0;
         set_eflags   <= MASK_NONE;
         eflags_out   <= '0;
      end else begin
         result_valid <= op_valid;
         if (op_valid) begin
            alu_out    <= res;
            set_eflags <= mask;
            eflags_out <= flg & mask;   // unwritten flags read as zero
         end else begin
            set_eflags <= MASK_NONE;    // data and flag values hold
         end
      end
   end

endmodule

// File: test/alu_assertions.sv
module alu_assertions (
   input logic            clk,
   input logic            arst_n,
   input logic            result_valid,
   input alu_pkg::mmx_t   alu_out,
   input alu_pkg::flags_t set_eflags,
   input alu_pkg::flags_t eflags_out
);
   timeunit 1ns;
   timeprecision 1ps;
   import alu_pkg::*;

   int fail_count = 0;   // failed assertions so far

   reset_clears: assert property (@(posedge clk)
      !arst_n |-> (!result_valid && set_eflags == MASK_NONE))
      else begin
         $error("result_valid or set_eflags not cleared in reset");
         fail_count++;
      end

   // flags outside the written set read as zero
   masked_flags_zero: assert property (@(posedge clk) disable iff (!arst_n)
      result_valid |-> ((eflags_out & ~set_eflags) == MASK_NONE))
      else begin
         $error("eflags_out has bits outside set_eflags");
         fail_count++;
      end

   parity_rule: assert property (@(posedge clk) disable iff (!arst_n)
      (result_valid && set_eflags[FLAG_PF]) |-> (eflags_out[FLAG_PF] == ~^alu_out[7:0]))
      else begin
         $error("PF does not match low byte parity");
         fail_count++;
      end

endmodule

bind alu_core alu_assertions u_checks (.clk(clk), .arst_n(arst_n), .result_valid(result_valid),
   .alu_out(alu_out), .set_eflags(set_eflags), .eflags_out(eflags_out));

// File: test/alu_tb.sv
module alu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import alu_pkg::*;

   // about 510 cycles of tests, roughly doubled for margin
   localparam int CYCLE_LIMIT = 1000;

   logic     clk;
   logic     arst_n;
   logic     op_valid;
   alu_op_t  alu_op;
   opsize_t  opsize;
   mmx_t     a;
   mmx_t     b;
   logic     result_valid;
   mmx_t     alu_out;
   flags_t   set_eflags;
   flags_t   eflags_out;

   // expected outputs after the next rising edge
   logic        exp_valid;
   mmx_t        exp_out;
   flags_t      exp_mask;
   flags_t      exp_flags;
   logic [31:0] lcg_state = 32'd90809;
   opsize_t     sizes [3] = '{SIZE_8, SIZE_16, SIZE_32};
   logic [3:0]  op_codes [12] = '{0, 1, 2, 4, 7, 8, 9, 10, 11, 12, 13, 5};   // 5 is unused

   alu_core uut (.clk(clk), .arst_n(arst_n), .op_valid(op_valid), .alu_op(alu_op),
                 .opsize(opsize), .a(a), .b(b), .result_valid(result_valid),
                 .alu_out(alu_out), .set_eflags(set_eflags), .eflags_out(eflags_out));

   always #4 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic mmx_t rand64();
      return {next_rand(), next_rand()};
   endfunction

   function automatic int width_of(input opsize_t size);
      case (size)
         SIZE_8:  return 8;
         SIZE_16: return 16;
         default: return 32;
      endcase
   endfunction

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string name, input mmx_t expv, input mmx_t act);
      if (expv !== act) begin
         $display("ERR %s: expected %h, got %h", name, expv, act);
         abort_run();
      end
   endtask

   task automatic check_flags(input string name, input flags_t expv, input flags_t act);
      if (expv !== act) begin
         $display("ERR %s: expected %h, got %h", name, expv, act);
         abort_run();
      end
   endtask

   task automatic check_valid(input string name, input logic expv, input logic act);
      if (expv !== act) begin
         $display("ERR %s: expected %h, got %h", name, expv, act);
         abort_run();
      end
   endtask

   // reference model from the ALU rules
   task automatic predict(input alu_op_t op, input opsize_t size, input mmx_t x, input mmx_t y,
                          output mmx_t res, output flags_t flg, output flags_t msk);
      int                 w;
      int                 n;
      logic [32:0]        wide;
      word_t              m;
      word_t              v;
      logic               cy;
      logic               sgn;
      logic signed [15:0] la;
      logic signed [15:0] lb;
      w   = width_of(size);
      m   = (w == 32) ? 32'hffff_ffff : (32'h1 << w) - 32'h1;
      res = '0;
      flg = '0;
      msk = MASK_NONE;
      case (op)
         ALU_PASS: res = x;
         ALU_ADD: begin
            wide = {1'b0, x[31:0] & m} + {1'b0, y[31:0] & m};
            v    = wide[31:0] & m;
            res  = {32'h0, v};
            flg[FLAG_CF] = wide[w];
            flg[FLAG_SF] = v[w-1];
            flg[FLAG_ZF] = (v == 0);
            flg[FLAG_AF] = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
            flg[FLAG_OF] = (x[w-1] == y[w-1]) && (v[w-1] != x[w-1]);
            msk = MASK_ARITH;
         end
         ALU_AND, ALU_OR, ALU_NOT: begin
            if (op == ALU_AND) v = x[31:0] & y[31:0];
            else if (op == ALU_OR) v = x[31:0] | y[31:0];
            else v = ~x[31:0];
            v   = v & m;
            res = {32'h0, v};
            flg[FLAG_SF] = v[w-1];
            flg[FLAG_ZF] = (v == 0);
            msk = (op == ALU_NOT) ? MASK_NONE : MASK_LOGIC;   // NOT leaves flags alone
         end
         ALU_SAL, ALU_SAR: begin
            n  = y[4:0];
            v  = x[31:0] & m;
            cy = 1'b0;
            for (int i = 0; i < n; i++) begin   // one bit per step
               if (op == ALU_SAL) begin
                  cy = v[w-1];
                  v  = (v << 1) & m;
               end else begin
                  cy     = v[0];
                  sgn    = v[w-1];
                  v      = v >> 1;
                  v[w-1] = sgn;
               end
            end
            res = {32'h0, v};
            flg[FLAG_SF] = v[w-1];
            flg[FLAG_ZF] = (v == 0);
            flg[FLAG_CF] = cy;
            flg[FLAG_OF] = (op == ALU_SAL) && (v[w-1] ^ cy);
            if (n != 0) begin
               msk = MASK_SHIFT_BASE;
               msk[FLAG_OF] = (n == 1);
            end
         end
         ALU_PADDW: for (int i = 0; i < 4; i++) res[16*i +: 16] = x[16*i +: 16] + y[16*i +: 16];
         ALU_PADDD: begin
            res[31:0]  = x[31:0] + y[31:0];
            res[63:32] = x[63:32] + y[63:32];
         end
         ALU_PMAXSW, ALU_PMINSW: begin
            for (int i = 0; i < 4; i++) begin
               la = x[16*i +: 16];
               lb = y[16*i +: 16];
               if (op == ALU_PMAXSW) res[16*i +: 16] = (la > lb) ? la : lb;
               else res[16*i +: 16] = (la < lb) ? la : lb;
            end
         end
         default: res = '0;
      endcase
      flg[FLAG_PF] = ~^res[7:0];
   endtask

   task automatic check_pending();
      check_valid("result_valid", exp_valid, result_valid);
      check_data("alu_out", exp_out, alu_out);
      check_flags("set_eflags", exp_mask, set_eflags);
      check_flags("eflags_out", exp_flags, eflags_out);
   endtask

   // checks the previous op, then drives the next one
   task automatic issue(input alu_op_t op, input opsize_t size, input mmx_t x, input mmx_t y);
      mmx_t   res;
      flags_t flg;
      flags_t msk;
      @(negedge clk);
      check_pending();
      op_valid = 1'b1;
      alu_op   = op;
      opsize   = size;
      a        = x;
      b        = y;
      predict(op, size, x, y, res, flg, msk);
      exp_valid = 1'b1;
      exp_out   = res;
      exp_mask  = msk;
      exp_flags = flg & msk;
   endtask

   task automatic idle();
      @(negedge clk);
      check_pending();
      op_valid  = 1'b0;
      a         = rand64();   // ignored while op_valid is low
      b         = rand64();
      exp_valid = 1'b0;
      exp_mask  = MASK_NONE;   // alu_out and eflags_out hold
   endtask

   task automatic test_reset();
      check_valid("result_valid", 1'b0, result_valid);
      check_flags("set_eflags", MASK_NONE, set_eflags);
      arst_n = 1'b1;
      check_pending();
      idle();
      idle();
   endtask

   task automatic test_add();
      for (int s = 0; s < 3; s++) begin
         repeat (60) issue(ALU_ADD, sizes[s], rand64(), rand64());
      end
      issue(ALU_ADD, SIZE_8, 64'h7f, 64'h1);
      issue(ALU_ADD, SIZE_8, 64'hff, 64'h1);
      issue(ALU_ADD, SIZE_16, 64'hffff, 64'h1);
      idle();
   endtask

   task automatic test_logic();
      for (int s = 0; s < 3; s++) begin
         repeat (12) begin
            issue(ALU_AND, sizes[s], rand64(), rand64());
            issue(ALU_OR, sizes[s], rand64(), rand64());
            issue(ALU_NOT, sizes[s], rand64(), rand64());
         end
         issue(ALU_AND, sizes[s], rand64(), 64'h0);   // zero result
         issue(ALU_NOT, sizes[s], {32'h0, 32'hffff_ffff}, 64'h0);
      end
      idle();
   endtask

   task automatic test_shift();
      mmx_t    y;
      alu_op_t op;
      for (int s = 0; s < 3; s++) begin
         for (int k = 0; k < 2; k++) begin
            op = (k == 0) ? ALU_SAL : ALU_SAR;
            for (int n = 0; n < 12; n++) begin
               y = rand64();
               if (n < 2) y[4:0] = n[4:0];   // counts 0 and 1 first
               issue(op, sizes[s], rand64(), y);
            end
            issue(op, sizes[s], 64'h8000_8080, 64'd3);   // sign bit set at every size
         end
      end
      idle();
   endtask

   task automatic test_packed();
      repeat (15) begin
         issue(ALU_PADDW, SIZE_32, rand64(), rand64());
         issue(ALU_PADDD, SIZE_32, rand64(), rand64());
         issue(ALU_PMAXSW, SIZE_32, rand64(), rand64());
         issue(ALU_PMINSW, SIZE_32, rand64(), rand64());
      end
      issue(ALU_PADDW, SIZE_32, 64'h7fff_ffff_0001_8000, 64'h0001_0001_ffff_8000);   // lane wrap
      issue(ALU_PADDD, SIZE_32, 64'hffff_ffff_7fff_ffff, 64'h0000_0001_0000_0001);
      issue(ALU_PMAXSW, SIZE_32, 64'h8000_7fff_fffe_0000, 64'h7fff_8000_ffff_0000);
      issue(ALU_PMINSW, SIZE_32, 64'h8000_7fff_fffe_0000, 64'h7fff_8000_ffff_0000);
      repeat (10) issue(ALU_PASS, sizes[next_rand() % 3], rand64(), rand64());
      idle();
   endtask

   task automatic test_throughput();
      repeat (50) begin
         issue(alu_op_t'(op_codes[next_rand() % 12]), opsize_t'(next_rand() % 3 + 1),
               rand64(), rand64());
      end
      idle();
   endtask

   initial begin
      for (int cycles = 0; cycles < CYCLE_LIMIT; cycles++) @(posedge clk);
      $display("run timed out after %0d cycles", CYCLE_LIMIT);
      abort_run();
   end

   initial begin
      wait (uut.u_checks.fail_count != 0);
      $display("a bound assertion failed");
      abort_run();
   end

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b1;
      op_valid  = 1'b0;
      alu_op    = ALU_PASS;
      opsize    = SIZE_32;
      a         = '0;
      b         = '0;
      exp_valid = 1'b0;
      exp_out   = '0;
      exp_mask  = MASK_NONE;
      exp_flags = '0;
      #1 arst_n = 1'b0;             // clean falling edge after time zero
      repeat (3) @(negedge clk);   // reset spans 3 rising edges
      test_reset();
      test_add();
      test_logic();
      test_shift();
      test_packed();
      test_throughput();
      if (uut.u_checks.fail_count == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         $display("%0d assertion failures", uut.u_checks.fail_count);
         abort_run();
      end
   end

endmodule

// File: build.f
logic/alu_pkg.sv
logic/alu_adder.sv
logic/alu_logic_unit.sv
logic/alu_shifter.sv
logic/alu_packed_unit.sv
logic/alu_core.sv
test/alu_assertions.sv
test/alu_tb.sv
